/* rtl/user_io_pkg.sv */
//========================================
// user_io shared definitions: SPI opcodes,
// frame phases and PS/2 sizing constants
//========================================
`default_nettype none

package user_io_pkg;

	// first byte of every frame, sent by the IO controller
	typedef enum logic [7:0] {
		CMD_BUT_SW = 8'h01,
		CMD_KBD    = 8'h05,
		CMD_STATUS = 8'h1e,
		CMD_LEDS   = 8'h1f,
		CMD_JOY0   = 8'h60,
		CMD_JOY1   = 8'h61
	} io_cmd_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CMD,
		ST_DATA
	} frame_state_e;

	// byte index within a frame, saturates at all ones
	localparam int BYTE_IDX_W = 4;

	// returned on MISO while the command byte shifts in
	localparam logic [7:0] CORE_TYPE = 8'ha4;

	// scan code prefixes
	localparam logic [7:0] KEY_EXT_PREFIX   = 8'he0;
	localparam logic [7:0] KEY_BREAK_PREFIX = 8'hf0;

	// clk_sys cycles per PS/2 clock half period
	localparam int PS2_DIV   = 50;
	localparam int PS2_DIV_W = $clog2(PS2_DIV);

	// keyboard FIFO, a packet is only taken with this much room left
	localparam int PS2_FIFO_BITS     = 4;
	localparam int PS2_FIFO_DEPTH    = 2 ** PS2_FIFO_BITS;
	localparam int PS2_FIFO_CNT_W    = PS2_FIFO_BITS + 1;
	localparam int PS2_FIFO_MIN_FREE = 4;

	localparam int SPI_SYNC_STAGES = 2;

endpackage

`default_nettype wire

/* rtl/spi_bus_if.sv */
//========================================
// byte level link between the SPI shifter,
// frame FSM and command decoder
//========================================
`timescale 1ns/1ns
`default_nettype none

interface spi_bus_if
	import user_io_pkg::*;
();

	logic [7:0]            rx_byte;
	logic                  rx_valid;
	logic [BYTE_IDX_W-1:0] byte_idx;
	io_cmd_e               cmd;
	frame_state_e          phase;
	// reply byte, picked up by the shifter at the next byte boundary
	logic [7:0]            tx_byte;

	modport shifter (output rx_byte, output rx_valid, input tx_byte);

	modport fsm (input rx_byte, input rx_valid, output byte_idx, output cmd, output phase);

	modport decoder (
		input  rx_byte,
		input  rx_valid,
		input  byte_idx,
		input  cmd,
		input  phase,
		output tx_byte
	);

endinterface

`default_nettype wire

/* rtl/spi_shifter.sv */
//========================================
// SPI mode 0 slave shifter, oversampled in
// clk_sys, MSB first in both directions
//========================================
`timescale 1ns/1ns
`default_nettype none

module spi_shifter
	import user_io_pkg::*;
(
	input  logic          clk_sys,
	input  logic          SPI_SS_IO,
	input  logic          spi_clk_i,
	input  logic          spi_mosi_i,
	output logic          spi_miso_o,
	spi_bus_if.shifter    bus
);

	logic [SPI_SYNC_STAGES-1:0] sck_sync;
	logic [SPI_SYNC_STAGES-1:0] mosi_sync;
	logic                       sck_q;
	logic                       sck_s;
	logic                       mosi_s;
	logic                       sck_rise;
	logic                       sck_fall;
	logic [2:0]                 bit_cnt;
	logic [6:0]                 rx_shift;
	logic [7:0]                 tx_shift;

	assign sck_s    = sck_sync[SPI_SYNC_STAGES-1];
	assign mosi_s   = mosi_sync[SPI_SYNC_STAGES-1];
	assign sck_rise = sck_s & ~sck_q;
	assign sck_fall = ~sck_s & sck_q;

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			sck_sync     <= '0;
			mosi_sync    <= '0;
			sck_q        <= 1'b0;
			bit_cnt      <= 3'd0;
			rx_shift     <= 7'd0;
			bus.rx_valid <= 1'b0;
			tx_shift     <= CORE_TYPE;
			spi_miso_o   <= 1'b0;
		end else begin
			sck_sync     <= {sck_sync[SPI_SYNC_STAGES-2:0], spi_clk_i};
			mosi_sync    <= {mosi_sync[SPI_SYNC_STAGES-2:0], spi_mosi_i};
			sck_q        <= sck_s;
			bus.rx_valid <= sck_rise && bit_cnt == 3'd7;
			spi_miso_o   <= tx_shift[7];
			if (sck_rise) begin
				rx_shift <= {rx_shift[5:0], mosi_s};
				bit_cnt  <= bit_cnt + 3'd1;
			end
			// bit_cnt wraps to 0 on the eighth rise, so this fall opens the next byte
			if (sck_fall) begin
				if (bit_cnt == 3'd0)
					tx_shift <= bus.tx_byte;
				else
					tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

	// completed byte
	always_ff @(posedge clk_sys) begin
		if (sck_rise && bit_cnt == 3'd7)
			bus.rx_byte <= {rx_shift, mosi_s};
	end

endmodule

`default_nettype wire

/* rtl/spi_frame_fsm.sv */
//========================================
// frame phase tracking, command latch and
// saturating byte index
//========================================
`timescale 1ns/1ns
`default_nettype none

module spi_frame_fsm
	import user_io_pkg::*;
(
	input  logic   clk_sys,
	input  logic   SPI_SS_IO,
	spi_bus_if.fsm bus
);

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bus.phase    <= ST_IDLE;
			bus.byte_idx <= '0;
			bus.cmd      <= io_cmd_e'(8'h00);
		end else begin
			case (bus.phase)
				// SS just went low, wait for the command byte
				ST_IDLE: bus.phase <= ST_CMD;
				ST_CMD: begin
					if (bus.rx_valid) begin
						// unknown opcodes are kept too, the decoder skips them
						bus.cmd   <= io_cmd_e'(bus.rx_byte);
						bus.phase <= ST_DATA;
					end
				end
				ST_DATA: bus.phase <= ST_DATA;
				default: bus.phase <= ST_IDLE;
			endcase

			if (bus.rx_valid && bus.byte_idx != '1)
				bus.byte_idx <= bus.byte_idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/io_cmd_decoder.sv */
//========================================
// command decoder: output registers, key
// strobes, PS/2 feed and MISO reply byte
//========================================
`timescale 1ns/1ns
`default_nettype none

module io_cmd_decoder
	import user_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        SPI_SS_IO,
	spi_bus_if.decoder  bus,
	input  logic [7:0]  leds_i,
	input  logic        kbd_ready_i,
	output logic        kbd_wr_o,
	output logic [7:0]  kbd_byte_o,
	output logic [7:0]  but_sw_o,
	output logic [31:0] joystick_0_o,
	output logic [31:0] joystick_1_o,
	output logic [63:0] status_o,
	output logic [7:0]  key_code_o,
	output logic        key_pressed_o,
	output logic        key_extended_o,
	output logic        key_strobe_o
);

	logic [7:0]  but_sw_q       = '0;
	logic [31:0] joy0_q         = '0;
	logic [31:0] joy1_q         = '0;
	logic [63:0] status_q       = '0;
	logic [7:0]  key_code_q     = '0;
	logic        key_pressed_q  = 1'b0;
	logic        key_extended_q = 1'b0;

	logic                  cmd_rx;
	logic                  data_rx;
	logic                  kbd_data;
	logic                  key_hit;
	logic [BYTE_IDX_W-1:0] lane_idx;
	// packet state
	logic                  kbd_ok;
	logic                  key_pressed_r;
	logic                  key_ext_r;

	assign cmd_rx   = bus.rx_valid && bus.phase == ST_CMD;
	assign data_rx  = bus.rx_valid && bus.phase == ST_DATA;
	assign kbd_data = data_rx && bus.cmd == CMD_KBD && kbd_ok;
	assign key_hit  = kbd_data && bus.rx_byte != KEY_EXT_PREFIX &&
		bus.rx_byte != KEY_BREAK_PREFIX;
	// data byte n lands in lane n-1
	assign lane_idx = bus.byte_idx - 1'b1;

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			kbd_ok        <= 1'b0;
			key_pressed_r <= 1'b1;
			key_ext_r     <= 1'b0;
			key_strobe_o  <= 1'b0;
			kbd_wr_o      <= 1'b0;
		end else begin
			key_strobe_o <= key_hit;
			kbd_wr_o     <= kbd_data;
			if (cmd_rx) begin
				// whole packet or nothing, room is checked only here
				kbd_ok        <= bus.rx_byte == CMD_KBD && kbd_ready_i;
				key_pressed_r <= 1'b1;
				key_ext_r     <= 1'b0;
			end else if (kbd_data) begin
				if (bus.rx_byte == KEY_EXT_PREFIX) begin
					key_ext_r <= 1'b1;
				end else if (bus.rx_byte == KEY_BREAK_PREFIX) begin
					key_pressed_r <= 1'b0;
				end else begin
					key_pressed_r <= 1'b1;
					key_ext_r     <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_rx) begin
			case (bus.cmd)
				CMD_BUT_SW: but_sw_q <= bus.rx_byte;
				CMD_JOY0: begin
					if (bus.byte_idx <= 4'd4)
						joy0_q[{lane_idx[1:0], 3'b000} +: 8] <= bus.rx_byte;
				end
				CMD_JOY1: begin
					if (bus.byte_idx <= 4'd4)
						joy1_q[{lane_idx[1:0], 3'b000} +: 8] <= bus.rx_byte;
				end
				CMD_STATUS: begin
					if (bus.byte_idx <= 4'd8)
						status_q[{lane_idx[2:0], 3'b000} +: 8] <= bus.rx_byte;
				end
				default: ;
			endcase
		end
		if (key_hit) begin
			key_code_q     <= bus.rx_byte;
			key_pressed_q  <= key_pressed_r;
			key_extended_q <= key_ext_r;
		end
		if (kbd_data)
			kbd_byte_o <= bus.rx_byte;
	end

	// reply for the next byte on MISO
	always_comb begin
		case (bus.phase)
			ST_DATA: bus.tx_byte = (bus.cmd == CMD_LEDS) ? leds_i : 8'h00;
			default: bus.tx_byte = CORE_TYPE;
		endcase
	end

	assign but_sw_o       = but_sw_q;
	assign joystick_0_o   = joy0_q;
	assign joystick_1_o   = joy1_q;
	assign status_o       = status_q;
	assign key_code_o     = key_code_q;
	assign key_pressed_o  = key_pressed_q;
	assign key_extended_o = key_extended_q;

endmodule

`default_nettype wire

/* rtl/ps2_clk_div.sv */
//========================================
// PS/2 bit clock divider with a tick on
// every rising edge
//========================================
`timescale 1ns/1ns
`default_nettype none

module ps2_clk_div
	import user_io_pkg::*;
(
	input  logic clk_sys,
	output logic ps2_clk_o,
	output logic tick_o
);

	logic [PS2_DIV_W-1:0] div_cnt   = '0;
	logic                 ps2_clk_q = 1'b0;
	logic                 tick_q    = 1'b0;

	always_ff @(posedge clk_sys) begin
		tick_q <= 1'b0;
		if (div_cnt == PS2_DIV_W'(PS2_DIV - 1)) begin
			div_cnt   <= '0;
			ps2_clk_q <= ~ps2_clk_q;
			// clock about to go high
			tick_q    <= ~ps2_clk_q;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign ps2_clk_o = ps2_clk_q;
	assign tick_o    = tick_q;

endmodule

`default_nettype wire

/* rtl/ps2_kbd_tx.sv */
//========================================
// PS/2 keyboard device to host sender with
// a small byte FIFO
//========================================
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_tx
	import user_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       ps2_clk_i,
	input  logic       tick_i,
	input  logic       wr_i,
	input  logic [7:0] byte_i,
	output logic       ready_o,
	output logic       ps2_clk_o,
	output logic       ps2_data_o
);

	logic [7:0]                fifo_mem [PS2_FIFO_DEPTH];
	logic [PS2_FIFO_BITS-1:0]  wptr     = '0;
	logic [PS2_FIFO_BITS-1:0]  rptr     = '0;
	logic [PS2_FIFO_CNT_W-1:0] fill     = '0;
	logic                      push;
	logic                      pop;

	logic [3:0] tx_step  = 4'd0;
	logic [7:0] tx_shift = 8'd0;
	logic       parity   = 1'b1;
	logic       data_q   = 1'b1;

	// full writes are dropped, the decoder checks room per packet
	assign push    = wr_i && fill != PS2_FIFO_CNT_W'(PS2_FIFO_DEPTH);
	assign pop     = tick_i && tx_step == 4'd0 && fill != '0;
	assign ready_o = fill <= PS2_FIFO_CNT_W'(PS2_FIFO_DEPTH - PS2_FIFO_MIN_FREE);

	always_ff @(posedge clk_sys) begin
		if (push) begin
			fifo_mem[wptr] <= byte_i;
			wptr           <= wptr + 1'b1;
		end
		if (pop)
			rptr <= rptr + 1'b1;
		if (push && !pop)
			fill <= fill + 1'b1;
		else if (pop && !push)
			fill <= fill - 1'b1;
	end

	// steps 1..8 data LSB first, 9 parity, 10 stop, 11 back to idle
	always_ff @(posedge clk_sys) begin
		if (tick_i) begin
			if (tx_step == 4'd0) begin
				data_q <= 1'b1;
				if (pop) begin
					tx_shift <= fifo_mem[rptr];
					parity   <= 1'b1;
					data_q   <= 1'b0;
					tx_step  <= 4'd1;
				end
			end else begin
				if (tx_step <= 4'd8) begin
					data_q   <= tx_shift[0];
					tx_shift <= {1'b0, tx_shift[7:1]};
					parity   <= parity ^ tx_shift[0];
				end else if (tx_step == 4'd9) begin
					data_q <= parity;
				end else begin
					data_q <= 1'b1;
				end
				tx_step <= (tx_step == 4'd11) ? 4'd0 : tx_step + 4'd1;
			end
		end
	end

	// no clock pulses on the line while nothing is being sent
	assign ps2_clk_o  = ps2_clk_i | (tx_step == 4'd0);
	assign ps2_data_o = data_q;

endmodule

`default_nettype wire

/* rtl/user_io_top.sv */
//========================================
// user_io top: SPI command slave with PS/2
// keyboard emulation
//========================================
`timescale 1ns/1ns
`default_nettype none

module user_io_top (
	input  logic        clk_sys,
	input  logic        SPI_SS_IO,
	input  logic        spi_clk_i,
	input  logic        spi_mosi_i,
	input  logic [7:0]  leds_i,
	output logic        spi_miso_o,
	output logic [1:0]  buttons_o,
	output logic [1:0]  switches_o,
	output logic        scandoubler_disable_o,
	output logic        ypbpr_o,
	output logic        no_csync_o,
	output logic [31:0] joystick_0_o,
	output logic [31:0] joystick_1_o,
	output logic [63:0] status_o,
	output logic [7:0]  key_code_o,
	output logic        key_pressed_o,
	output logic        key_extended_o,
	output logic        key_strobe_o,
	output logic        ps2_kbd_clk_o,
	output logic        ps2_kbd_data_o
);

	logic [7:0] but_sw;
	logic       kbd_wr;
	logic [7:0] kbd_byte;
	logic       kbd_ready;
	logic       ps2_clk;
	logic       ps2_tick;

	spi_bus_if u_spi_bus ();

	spi_shifter u_spi_shifter (
		.clk_sys    (clk_sys),
		.SPI_SS_IO  (SPI_SS_IO),
		.spi_clk_i  (spi_clk_i),
		.spi_mosi_i (spi_mosi_i),
		.spi_miso_o (spi_miso_o),
		.bus        (u_spi_bus.shifter)
	);

	spi_frame_fsm u_spi_frame_fsm (
		.clk_sys   (clk_sys),
		.SPI_SS_IO (SPI_SS_IO),
		.bus       (u_spi_bus.fsm)
	);

	io_cmd_decoder u_io_cmd_decoder (
		.clk_sys        (clk_sys),
		.SPI_SS_IO      (SPI_SS_IO),
		.bus            (u_spi_bus.decoder),
		.leds_i         (leds_i),
		.kbd_ready_i    (kbd_ready),
		.kbd_wr_o       (kbd_wr),
		.kbd_byte_o     (kbd_byte),
		.but_sw_o       (but_sw),
		.joystick_0_o   (joystick_0_o),
		.joystick_1_o   (joystick_1_o),
		.status_o       (status_o),
		.key_code_o     (key_code_o),
		.key_pressed_o  (key_pressed_o),
		.key_extended_o (key_extended_o),
		.key_strobe_o   (key_strobe_o)
	);

	ps2_clk_div u_ps2_clk_div (
		.clk_sys   (clk_sys),
		.ps2_clk_o (ps2_clk),
		.tick_o    (ps2_tick)
	);

	ps2_kbd_tx u_ps2_kbd_tx (
		.clk_sys    (clk_sys),
		.ps2_clk_i  (ps2_clk),
		.tick_i     (ps2_tick),
		.wr_i       (kbd_wr),
		.byte_i     (kbd_byte),
		.ready_o    (kbd_ready),
		.ps2_clk_o  (ps2_kbd_clk_o),
		.ps2_data_o (ps2_kbd_data_o)
	);

	// button and switch byte fields, bit 7 unused
	assign buttons_o             = but_sw[1:0];
	assign switches_o            = but_sw[3:2];
	assign scandoubler_disable_o = but_sw[4];
	assign ypbpr_o               = but_sw[5];
	assign no_csync_o            = but_sw[6];

endmodule

`default_nettype wire

/* test/user_io_checker.sv */
//========================================
// protocol assertions for user_io_top
//========================================
`timescale 1ns/1ns
`default_nettype none

module user_io_checker (
	input logic       clk_sys,
	input logic       SPI_SS_IO,
	input logic       key_strobe_o,
	input logic       spi_miso_o,
	input logic       ps2_kbd_clk_o,
	input logic [3:0] ps2_tx_step
);

	// key strobe is a single cycle pulse
	assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		key_strobe_o |=> !key_strobe_o)
		else $error("key_strobe_o high for two cycles");

	// MISO parked low outside a frame
	assert property (@(posedge clk_sys) SPI_SS_IO |-> !spi_miso_o)
		else $error("spi_miso_o not low while SPI_SS_IO is high");

	// no PS/2 clock pulses while the serialiser is idle
	assert property (@(posedge clk_sys) ps2_tx_step == 4'd0 |-> ps2_kbd_clk_o)
		else $error("ps2_kbd_clk_o low while the serialiser is idle");

endmodule

bind user_io_top user_io_checker u_user_io_checker (
	.clk_sys       (clk_sys),
	.SPI_SS_IO     (SPI_SS_IO),
	.key_strobe_o  (key_strobe_o),
	.spi_miso_o    (spi_miso_o),
	.ps2_kbd_clk_o (ps2_kbd_clk_o),
	.ps2_tx_step   (u_ps2_kbd_tx.tx_step)
);

`default_nettype wire

/* test/tb_user_io.sv */
//========================================
// testbench for user_io_top: SPI frames,
// key strobes and PS/2 keyboard output
//========================================
`timescale 1ns/1ns
`default_nettype none

module tb_user_io
	import user_io_pkg::*;
();

	typedef logic [7:0] byte_q_t [$];

	// clk_sys cycles per SPI half period
	localparam int SPI_HALF     = 8;
	localparam int N_FRAMES     = 7;
	localparam int FRAME_CYCLES = 9 * 16 * SPI_HALF + 4 * SPI_HALF;
	// one PS/2 byte takes 12 clock periods including the idle slot
	localparam int PS2_DRAIN    = 7 * 12 * 2 * PS2_DIV;
	localparam int WATCHDOG     = 2 * (N_FRAMES * FRAME_CYCLES + PS2_DRAIN) + 100;

	logic        clk_sys;
	logic        SPI_SS_IO;
	logic        spi_clk_i;
	logic        spi_mosi_i;
	logic [7:0]  leds_i;
	logic        spi_miso_o;
	logic [1:0]  buttons_o;
	logic [1:0]  switches_o;
	logic        scandoubler_disable_o;
	logic        ypbpr_o;
	logic        no_csync_o;
	logic [31:0] joystick_0_o;
	logic [31:0] joystick_1_o;
	logic [63:0] status_o;
	logic [7:0]  key_code_o;
	logic        key_pressed_o;
	logic        key_extended_o;
	logic        key_strobe_o;
	logic        ps2_kbd_clk_o;
	logic        ps2_kbd_data_o;

	integer seed = 98;
	int err_cnt = 0;
	int err_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// expected register image
	logic [7:0]  exp_but_sw = '0;
	logic [31:0] exp_joy0   = '0;
	logic [31:0] exp_joy1   = '0;
	logic [63:0] exp_status = '0;
	// key events packed as {code, pressed, extended}
	logic [9:0]  exp_key_q [$];
	logic [9:0]  got_key_q [$];
	logic [7:0]  exp_ps2_q [$];
	logic [7:0]  got_ps2_q [$];
	logic [7:0]  exp_miso_q [$];
	logic [7:0]  got_miso_q [$];

	user_io_top u_user_io_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic byte_q_t random_frame(input logic [7:0] cmd, input int n);
		byte_q_t q;
		q.push_back(cmd);
		repeat (n) q.push_back(rand_byte());
		return q;
	endfunction

	// reference model of one whole frame
	function automatic void model_frame(input byte_q_t frame);
		logic [7:0] cmd;
		logic       pressed;
		logic       ext;
		cmd = frame[0];
		pressed = 1'b1;
		ext = 1'b0;
		exp_miso_q.delete();
		exp_miso_q.push_back(CORE_TYPE);
		for (int i = 1; i < frame.size(); i++) begin
			exp_miso_q.push_back((cmd == CMD_LEDS) ? leds_i : 8'h00);
			if (cmd == CMD_BUT_SW)
				exp_but_sw = frame[i];
			else if (cmd == CMD_JOY0 && i <= 4)
				exp_joy0[8*(i-1) +: 8] = frame[i];
			else if (cmd == CMD_JOY1 && i <= 4)
				exp_joy1[8*(i-1) +: 8] = frame[i];
			else if (cmd == CMD_STATUS && i <= 8)
				exp_status[8*(i-1) +: 8] = frame[i];
			else if (cmd == CMD_KBD) begin
				exp_ps2_q.push_back(frame[i]);
				if (frame[i] == KEY_EXT_PREFIX)
					ext = 1'b1;
				else if (frame[i] == KEY_BREAK_PREFIX)
					pressed = 1'b0;
				else begin
					exp_key_q.push_back({frame[i], pressed, ext});
					pressed = 1'b1;
					ext = 1'b0;
				end
			end
		end
	endfunction

	task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			err_cnt++;
		end
	endtask

	// mode 0 MSB first with MISO captured on each rising SPI edge
	task automatic send_frame(input byte_q_t frame);
		logic [7:0] miso_byte;
		miso_byte = 8'h00;
		got_miso_q.delete();
		@(posedge clk_sys);
		SPI_SS_IO <= 1'b0;
		foreach (frame[i]) begin
			for (int b = 7; b >= 0; b--) begin
				spi_mosi_i <= frame[i][b];
				repeat (SPI_HALF) @(posedge clk_sys);
				spi_clk_i <= 1'b1;
				miso_byte = {miso_byte[6:0], spi_miso_o};
				repeat (SPI_HALF) @(posedge clk_sys);
				spi_clk_i <= 1'b0;
			end
			got_miso_q.push_back(miso_byte);
		end
		repeat (SPI_HALF) @(posedge clk_sys);
		SPI_SS_IO <= 1'b1;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic run_frame(input byte_q_t frame);
		send_frame(frame);
		model_frame(frame);
		foreach (exp_miso_q[i])
			check_hex("spi_miso_o", got_miso_q[i], exp_miso_q[i]);
	endtask

	task automatic check_regs();
		check_hex("buttons_o", buttons_o, exp_but_sw[1:0]);
		check_hex("switches_o", switches_o, exp_but_sw[3:2]);
		check_hex("scandoubler_disable_o", scandoubler_disable_o, exp_but_sw[4]);
		check_hex("ypbpr_o", ypbpr_o, exp_but_sw[5]);
		check_hex("no_csync_o", no_csync_o, exp_but_sw[6]);
		check_hex("joystick_0_o", joystick_0_o, exp_joy0);
		check_hex("joystick_1_o", joystick_1_o, exp_joy1);
		check_hex("status_o", status_o, exp_status);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_cnt > err_mark) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		err_mark = err_cnt;
	endtask

	// key strobe recorder
	always @(posedge clk_sys) begin
		if (key_strobe_o === 1'b1)
			got_key_q.push_back({key_code_o, key_pressed_o, key_extended_o});
	end

	// PS/2 monitor sampling data on falling clock edges
	initial begin : ps2_monitor
		logic [10:0] bits;
		forever begin
			for (int k = 0; k < 11; k++) begin
				@(negedge ps2_kbd_clk_o);
				bits[k] = ps2_kbd_data_o;
			end
			assert (bits[0] == 1'b0 && bits[10] == 1'b1 && ^bits[9:1] == 1'b1) else begin
				$display("PS/2 frame with data 0x%h has a bad start, parity or stop bit",
					bits[8:1]);
				err_cnt++;
			end
			got_ps2_q.push_back(bits[8:1]);
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG) @(posedge clk_sys);
		$display("watchdog expired before all tests finished");
		$display("TB FAILED");
		$finish;
	end

	initial begin : main
		byte_q_t frame;
		int wait_cycles;
		SPI_SS_IO = 1'b1;
		spi_clk_i = 1'b0;
		spi_mosi_i = 1'b0;
		leds_i = 8'h00;
		repeat (3) @(posedge clk_sys);

		run_frame(random_frame(CMD_BUT_SW, 1));
		check_regs();
		finish_test("buttons and switches");

		run_frame(random_frame(CMD_JOY0, 6));
		run_frame(random_frame(CMD_JOY1, 6));
		check_regs();
		finish_test("digital joysticks");

		run_frame(random_frame(CMD_STATUS, 8));
		check_regs();
		// unknown opcode leaves the image alone
		run_frame(random_frame(8'h42, 4));
		check_regs();
		finish_test("status word and unknown opcode");

		@(posedge clk_sys);
		leds_i <= rand_byte();
		run_frame(random_frame(CMD_LEDS, 3));
		finish_test("MISO core type and LEDs");

		frame = {8'h05, 8'h1c, 8'he0, 8'h75, 8'he0, 8'hf0, 8'h75};
		run_frame(frame);
		assert (got_key_q.size() == exp_key_q.size()) else begin
			$display("key strobe count %0d differs from the expected %0d", got_key_q.size(),
				exp_key_q.size());
			err_cnt++;
		end
		foreach (exp_key_q[i]) begin
			if (i < got_key_q.size()) begin
				check_hex("key_code_o", got_key_q[i][9:2], exp_key_q[i][9:2]);
				check_hex("key_pressed_o", got_key_q[i][1], exp_key_q[i][1]);
				check_hex("key_extended_o", got_key_q[i][0], exp_key_q[i][0]);
			end
		end
		finish_test("keyboard strobes");

		wait_cycles = 0;
		while (got_ps2_q.size() < exp_ps2_q.size() && wait_cycles < PS2_DRAIN) begin
			@(posedge clk_sys);
			wait_cycles++;
		end
		assert (got_ps2_q.size() == exp_ps2_q.size()) else begin
			$display("PS/2 monitor received %0d of %0d bytes", got_ps2_q.size(),
				exp_ps2_q.size());
			err_cnt++;
		end
		foreach (exp_ps2_q[i])
			if (i < got_ps2_q.size())
				check_hex("ps2_kbd_data_o byte", got_ps2_q[i], exp_ps2_q[i]);
		finish_test("PS/2 keyboard output");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/user_io_pkg.sv
rtl/spi_bus_if.sv
rtl/spi_shifter.sv
rtl/spi_frame_fsm.sv
rtl/io_cmd_decoder.sv
rtl/ps2_clk_div.sv
rtl/ps2_kbd_tx.sv
rtl/user_io_top.sv
test/user_io_checker.sv
test/tb_user_io.sv

/* Bender.yml */
package:
  name: user_io

sources:
  - rtl/user_io_pkg.sv
  - rtl/spi_bus_if.sv
  - rtl/spi_shifter.sv
  - rtl/spi_frame_fsm.sv
  - rtl/io_cmd_decoder.sv
  - rtl/ps2_clk_div.sv
  - rtl/ps2_kbd_tx.sv
  - rtl/user_io_top.sv
  - target: test
    files:
      - test/user_io_checker.sv
      - test/tb_user_io.sv
